// ==== common/riscvPkg.sv ====
package riscvPkg;

    localparam int XLEN       = 32; // data and address width
    localparam int REG_ADDR_W = 5;  // x0..x31

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011, // lw
        OP_STORE  = 7'b0100011, // sw
        OP_RTYPE  = 7'b0110011, // add sub and or slt
        OP_BRANCH = 7'b1100011, // beq
        OP_IMM    = 7'b0010011, // addi
        OP_JAL    = 7'b1101111
    } opcodeE;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b101  // unsigned less-than
    } aluOpE;

    // immediate layouts
    typedef enum logic [1:0] {
        IMM_I = 2'b00,
        IMM_S = 2'b01,
        IMM_B = 2'b10,
        IMM_J = 2'b11
    } immTypeE;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01, // loaded word
        RES_PC4 = 2'b10  // link address
    } resultSrcE;

    // operand source in execute
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00, // register file value
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10
    } fwdSelE;

endpackage

// ==== design/controlDecoder.sv ====
`timescale 1ns/1ns

module controlDecoder import riscvPkg::*; (
    input  opcodeE     opcode,
    input  logic [2:0] funct3,
    input  logic       funct7b5,
    output logic       regWrite,
    output logic       aluSrc,
    output logic       memWrite,
    output logic       jump,
    output logic       branch,
    output immTypeE    immType,
    output resultSrcE  resultSrc,
    output aluOpE      aluOp
);

    // coarse ALU choice handed from main decoder to ALU decoder
    typedef enum logic [1:0] {
        ALU_CLS_ADD,   // address calc
        ALU_CLS_SUB,   // compare for beq
        ALU_CLS_FUNCT  // picked by funct3
    } aluClassE;

    aluClassE aluClass;
    logic     rtypeSub;

    ////////////////////
    // main decoder
    always_comb begin
        regWrite  = 1'b0; // all inactive by default, bubble does nothing
        aluSrc    = 1'b0;
        memWrite  = 1'b0;
        jump      = 1'b0;
        branch    = 1'b0;
        immType   = IMM_I;
        resultSrc = RES_ALU;
        aluClass  = ALU_CLS_ADD;
        case (opcode)
            OP_LOAD: begin
                regWrite  = 1'b1;
                aluSrc    = 1'b1;
                resultSrc = RES_MEM;
            end
            OP_STORE: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
                immType  = IMM_S;
            end
            OP_RTYPE: begin
                regWrite = 1'b1;
                aluClass = ALU_CLS_FUNCT;
            end
            OP_BRANCH: begin
                branch   = 1'b1;
                immType  = IMM_B;
                aluClass = ALU_CLS_SUB; // zero flag means equal
            end
            OP_IMM: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluClass = ALU_CLS_FUNCT;
            end
            OP_JAL: begin
                regWrite  = 1'b1;
                jump      = 1'b1;
                immType   = IMM_J;
                resultSrc = RES_PC4; // rd gets pc+4
            end
            default: ;
        endcase
    end

    ////////////////////
    // ALU decoder
    assign rtypeSub = funct7b5 && (opcode == OP_RTYPE); // addi never subtracts

    always_comb begin
        case (aluClass)
            ALU_CLS_SUB:   aluOp = ALU_SUB;
            ALU_CLS_FUNCT: begin
                case (funct3)
                    3'b000:  aluOp = rtypeSub ? ALU_SUB : ALU_ADD;
                    3'b010:  aluOp = ALU_SLT;
                    3'b110:  aluOp = ALU_OR;
                    3'b111:  aluOp = ALU_AND;
                    default: aluOp = ALU_ADD;
                endcase
            end
            default:       aluOp = ALU_ADD; // lw / sw
        endcase
    end

endmodule

// ==== design/forwardingUnit.sv ====
`timescale 1ns/1ns

module forwardingUnit import riscvPkg::*; (
    input  logic [REG_ADDR_W-1:0] rs1E,
    input  logic [REG_ADDR_W-1:0] rs2E,
    input  logic [REG_ADDR_W-1:0] rdM,
    input  logic                  regWriteM,
    input  logic [REG_ADDR_W-1:0] rdW,
    input  logic                  regWriteW,
    output fwdSelE                fwdA,
    output fwdSelE                fwdB
);

    // newest producer wins, x0 never forwarded
    function automatic fwdSelE pickSrc(input logic [REG_ADDR_W-1:0] rs);
        if (rs != '0 && rs == rdM && regWriteM)
            return FWD_MEM;
        else if (rs != '0 && rs == rdW && regWriteW)
            return FWD_WB;
        return FWD_NONE;
    endfunction

    always_comb begin
        fwdA = pickSrc(rs1E);
        fwdB = pickSrc(rs2E);
    end

endmodule

// ==== fetch/fetchStage.sv ====
`timescale 1ns/1ns

module fetchStage import riscvPkg::*; #(
    parameter int IMEM_ADDR_W = 11
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   takenE,
    input  logic [XLEN-1:0]        targetE,
    input  logic [XLEN-1:0]        imemData,
    output logic [IMEM_ADDR_W-1:0] imemAddr,
    output logic [XLEN-1:0]        instrD,
    output logic [XLEN-1:0]        pcD,
    output logic [XLEN-1:0]        pcPlus4D
);

    logic [XLEN-1:0] pcF;
    logic [XLEN-1:0] pcPlus4F;
    logic [XLEN-1:0] pcNext;

    assign pcPlus4F = pcF + XLEN'(4);
    assign pcNext   = takenE ? targetE : pcPlus4F; // redirect from execute
    assign imemAddr = pcF[IMEM_ADDR_W+1:2];        // word address

    // pc plus fetch/decode register
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pcF      <= '0;
            instrD   <= '0; // opcode 0 decodes as a bubble
            pcD      <= '0;
            pcPlus4D <= '0;
        end else begin
            pcF      <= pcNext;
            instrD   <= imemData;
            pcD      <= pcF;
            pcPlus4D <= pcPlus4F;
        end
    end

endmodule

// ==== decode/regFile.sv ====
`timescale 1ns/1ns

module regFile import riscvPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    input  logic [REG_ADDR_W-1:0] rd,
    input  logic                  we,
    input  logic [XLEN-1:0]       wd,
    output logic [XLEN-1:0]       rd1,
    output logic [XLEN-1:0]       rd2
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    // falling edge write, value visible to decode in the same cycle
    always_ff @(negedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[rd] <= wd;
        end
    end

    // x0 reads as zero whatever was written
    assign rd1 = (rs1 != '0) ? regs[rs1] : '0;
    assign rd2 = (rs2 != '0) ? regs[rs2] : '0;

endmodule

// ==== decode/decodeStage.sv ====
`timescale 1ns/1ns

module decodeStage import riscvPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [XLEN-1:0]       instrD,
    input  logic [XLEN-1:0]       pcD,
    input  logic [XLEN-1:0]       pcPlus4D,
    input  logic                  regWriteW,
    input  logic [REG_ADDR_W-1:0] rdW,
    input  logic [XLEN-1:0]       resultW,
    output logic [XLEN-1:0]       rd1E,
    output logic [XLEN-1:0]       rd2E,
    output logic [XLEN-1:0]       immE,
    output logic [XLEN-1:0]       pcE,
    output logic [XLEN-1:0]       pcPlus4E,
    output logic [REG_ADDR_W-1:0] rs1E,
    output logic [REG_ADDR_W-1:0] rs2E,
    output logic [REG_ADDR_W-1:0] rdE,
    output logic                  regWriteE,
    output logic                  memWriteE,
    output logic                  jumpE,
    output logic                  branchE,
    output logic                  aluSrcE,
    output riscvPkg::aluOpE       aluOpE,
    output riscvPkg::resultSrcE   resultSrcE
);

    logic [REG_ADDR_W-1:0] rs1D;
    logic [REG_ADDR_W-1:0] rs2D;
    logic [REG_ADDR_W-1:0] rdD;
    logic [XLEN-1:0]       rd1D;
    logic [XLEN-1:0]       rd2D;
    logic [XLEN-1:0]       immD;
    logic                  regWriteD;
    logic                  memWriteD;
    logic                  jumpD;
    logic                  branchD;
    logic                  aluSrcD;
    immTypeE               immTypeD;
    riscvPkg::aluOpE       aluOpD;
    riscvPkg::resultSrcE   resultSrcD;

    // field split
    assign rs1D = instrD[19:15];
    assign rs2D = instrD[24:20];
    assign rdD  = instrD[11:7];

    regFile rf (
        .clk (clk),
        .rst (rst),
        .rs1 (rs1D),
        .rs2 (rs2D),
        .rd  (rdW),       // writeback destination
        .we  (regWriteW),
        .wd  (resultW),
        .rd1 (rd1D),
        .rd2 (rd2D)
    );

    controlDecoder ctrl (
        .opcode    (opcodeE'(instrD[6:0])),
        .funct3    (instrD[14:12]),
        .funct7b5  (instrD[30]),
        .regWrite  (regWriteD),
        .aluSrc    (aluSrcD),
        .memWrite  (memWriteD),
        .jump      (jumpD),
        .branch    (branchD),
        .immType   (immTypeD),
        .resultSrc (resultSrcD),
        .aluOp     (aluOpD)
    );

    ////////////////////
    // immediate sign extension, bit 31 is always the sign
    always_comb begin
        case (immTypeD)
            IMM_S:   immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            IMM_B:   immD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
            IMM_J:   immD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
            default: immD = {{20{instrD[31]}}, instrD[31:20]}; // I type
        endcase
    end

    ////////////////////
    // decode/execute register
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rd1E       <= '0;
            rd2E       <= '0;
            immE       <= '0;
            pcE        <= '0;
            pcPlus4E   <= '0;
            rs1E       <= '0;
            rs2E       <= '0;
            rdE        <= '0;
            regWriteE  <= 1'b0;
            memWriteE  <= 1'b0;
            jumpE      <= 1'b0;
            branchE    <= 1'b0;
            aluSrcE    <= 1'b0;
            aluOpE     <= ALU_ADD;
            resultSrcE <= RES_ALU;
        end else begin
            rd1E       <= rd1D;
            rd2E       <= rd2D;
            immE       <= immD;
            pcE        <= pcD;
            pcPlus4E   <= pcPlus4D;
            rs1E       <= rs1D;
            rs2E       <= rs2D;
            rdE        <= rdD;
            regWriteE  <= regWriteD;
            memWriteE  <= memWriteD;
            jumpE      <= jumpD;
            branchE    <= branchD;
            aluSrcE    <= aluSrcD;
            aluOpE     <= aluOpD;
            resultSrcE <= resultSrcD;
        end
    end

endmodule

// ==== execute/executeStage.sv ====
`timescale 1ns/1ns

module executeStage import riscvPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [XLEN-1:0]       rd1E,
    input  logic [XLEN-1:0]       rd2E,
    input  logic [XLEN-1:0]       immE,
    input  logic [XLEN-1:0]       pcE,
    input  logic [XLEN-1:0]       pcPlus4E,
    input  logic [REG_ADDR_W-1:0] rdE,
    input  logic                  regWriteE,
    input  logic                  memWriteE,
    input  logic                  jumpE,
    input  logic                  branchE,
    input  logic                  aluSrcE,
    input  riscvPkg::aluOpE       aluOpE,
    input  riscvPkg::resultSrcE   resultSrcE,
    input  fwdSelE                fwdA,
    input  fwdSelE                fwdB,
    input  logic [XLEN-1:0]       aluResultFwd, // ALU result now in memory stage
    input  logic [XLEN-1:0]       resultW,
    output logic                  takenE,
    output logic [XLEN-1:0]       targetE,
    output logic [XLEN-1:0]       aluResultM,
    output logic [XLEN-1:0]       writeDataM,
    output logic [XLEN-1:0]       pcPlus4M,
    output logic [REG_ADDR_W-1:0] rdM,
    output logic                  regWriteM,
    output logic                  memWriteM,
    output riscvPkg::resultSrcE   resultSrcM
);

    logic [XLEN-1:0] srcA;
    logic [XLEN-1:0] fwdDataB; // also the store data
    logic [XLEN-1:0] srcB;
    logic [XLEN-1:0] aluResult;
    logic            zero;

    function automatic logic [XLEN-1:0] fwdMux(input fwdSelE sel, input logic [XLEN-1:0] regVal);
        case (sel)
            FWD_MEM: return aluResultFwd;
            FWD_WB:  return resultW;
            default: return regVal;
        endcase
    endfunction

    ////////////////////
    // operands and ALU
    always_comb begin
        srcA     = fwdMux(fwdA, rd1E);
        fwdDataB = fwdMux(fwdB, rd2E);
        srcB     = aluSrcE ? immE : fwdDataB;
        case (aluOpE)
            ALU_SUB: aluResult = srcA - srcB;
            ALU_AND: aluResult = srcA & srcB;
            ALU_OR:  aluResult = srcA | srcB;
            ALU_SLT: aluResult = (srcA < srcB) ? XLEN'(1) : '0; // unsigned
            default: aluResult = srcA + srcB;
        endcase
    end

    assign zero    = (aluResult == '0);
    assign targetE = pcE + immE;                 // beq and jal share the adder
    assign takenE  = (branchE && zero) || jumpE; // no flush behind it

    ////////////////////
    // execute/memory register
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            aluResultM <= '0;
            writeDataM <= '0;
            pcPlus4M   <= '0;
            rdM        <= '0;
            regWriteM  <= 1'b0;
            memWriteM  <= 1'b0; // no store out of reset
            resultSrcM <= RES_ALU;
        end else begin
            aluResultM <= aluResult;
            writeDataM <= fwdDataB;
            pcPlus4M   <= pcPlus4E;
            rdM        <= rdE;
            regWriteM  <= regWriteE;
            memWriteM  <= memWriteE;
            resultSrcM <= resultSrcE;
        end
    end

endmodule

// ==== design/memWriteback.sv ====
`timescale 1ns/1ns

module memWriteback import riscvPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [XLEN-1:0]       aluResultM,
    input  logic [XLEN-1:0]       dmemReadData, // combinational read of dmemAddr
    input  logic [XLEN-1:0]       pcPlus4M,
    input  logic [REG_ADDR_W-1:0] rdM,
    input  logic                  regWriteM,
    input  resultSrcE             resultSrcM,
    output logic [XLEN-1:0]       resultW,
    output logic [REG_ADDR_W-1:0] rdW,
    output logic                  regWriteW
);

    logic [XLEN-1:0] aluResultW;
    logic [XLEN-1:0] readDataW;
    logic [XLEN-1:0] pcPlus4W;
    resultSrcE       resultSrcW;

    // memory/writeback register
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            aluResultW <= '0;
            readDataW  <= '0;
            pcPlus4W   <= '0;
            rdW        <= '0;
            regWriteW  <= 1'b0;
            resultSrcW <= RES_ALU;
        end else begin
            aluResultW <= aluResultM;
            readDataW  <= dmemReadData;
            pcPlus4W   <= pcPlus4M;
            rdW        <= rdM;
            regWriteW  <= regWriteM;
            resultSrcW <= resultSrcM;
        end
    end

    always_comb begin
        case (resultSrcW)
            RES_MEM: resultW = readDataW;
            RES_PC4: resultW = pcPlus4W;  // jal link
            default: resultW = aluResultW;
        endcase
    end

endmodule

// ==== design/riscvCore.sv ====
`timescale 1ns/1ns

module riscvCore import riscvPkg::*; #(
    parameter int IMEM_ADDR_W = 11
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [XLEN-1:0]        imemData,
    output logic [IMEM_ADDR_W-1:0] imemAddr,
    input  logic [XLEN-1:0]        dmemReadData,
    output logic                   dmemWrite,
    output logic [XLEN-1:0]        dmemAddr,
    output logic [XLEN-1:0]        dmemWriteData
);

    // fetch -> decode
    logic [XLEN-1:0]       instrD;
    logic [XLEN-1:0]       pcD;
    logic [XLEN-1:0]       pcPlus4D;
    // decode -> execute
    logic [XLEN-1:0]       rd1E;
    logic [XLEN-1:0]       rd2E;
    logic [XLEN-1:0]       immE;
    logic [XLEN-1:0]       pcE;
    logic [XLEN-1:0]       pcPlus4E;
    logic [REG_ADDR_W-1:0] rs1E;
    logic [REG_ADDR_W-1:0] rs2E;
    logic [REG_ADDR_W-1:0] rdE;
    logic                  regWriteE;
    logic                  memWriteE;
    logic                  jumpE;
    logic                  branchE;
    logic                  aluSrcE;
    riscvPkg::aluOpE       aluOpE;
    riscvPkg::resultSrcE   resultSrcE;
    // execute -> fetch
    logic                  takenE;
    logic [XLEN-1:0]       targetE;
    fwdSelE                fwdA;
    fwdSelE                fwdB;
    // memory stage
    logic [XLEN-1:0]       aluResultM;
    logic [XLEN-1:0]       writeDataM;
    logic [XLEN-1:0]       pcPlus4M;
    logic [REG_ADDR_W-1:0] rdM;
    logic                  regWriteM;
    logic                  memWriteM;
    riscvPkg::resultSrcE   resultSrcM;
    // writeback -> register file
    logic [XLEN-1:0]       resultW;
    logic [REG_ADDR_W-1:0] rdW;
    logic                  regWriteW;

    fetchStage #(.IMEM_ADDR_W(IMEM_ADDR_W)) fetch (
        .clk      (clk),
        .rst      (rst),
        .takenE   (takenE),
        .targetE  (targetE),
        .imemData (imemData),
        .imemAddr (imemAddr),
        .instrD   (instrD),
        .pcD      (pcD),
        .pcPlus4D (pcPlus4D)
    );

    decodeStage decode (
        .clk        (clk),
        .rst        (rst),
        .instrD     (instrD),
        .pcD        (pcD),
        .pcPlus4D   (pcPlus4D),
        .regWriteW  (regWriteW),
        .rdW        (rdW),
        .resultW    (resultW),
        .rd1E       (rd1E),
        .rd2E       (rd2E),
        .immE       (immE),
        .pcE        (pcE),
        .pcPlus4E   (pcPlus4E),
        .rs1E       (rs1E),
        .rs2E       (rs2E),
        .rdE        (rdE),
        .regWriteE  (regWriteE),
        .memWriteE  (memWriteE),
        .jumpE      (jumpE),
        .branchE    (branchE),
        .aluSrcE    (aluSrcE),
        .aluOpE     (aluOpE),
        .resultSrcE (resultSrcE)
    );

    forwardingUnit fwd (
        .rs1E      (rs1E),
        .rs2E      (rs2E),
        .rdM       (rdM),
        .regWriteM (regWriteM),
        .rdW       (rdW),
        .regWriteW (regWriteW),
        .fwdA      (fwdA),
        .fwdB      (fwdB)
    );

    executeStage execute (
        .clk          (clk),
        .rst          (rst),
        .rd1E         (rd1E),
        .rd2E         (rd2E),
        .immE         (immE),
        .pcE          (pcE),
        .pcPlus4E     (pcPlus4E),
        .rdE          (rdE),
        .regWriteE    (regWriteE),
        .memWriteE    (memWriteE),
        .jumpE        (jumpE),
        .branchE      (branchE),
        .aluSrcE      (aluSrcE),
        .aluOpE       (aluOpE),
        .resultSrcE   (resultSrcE),
        .fwdA         (fwdA),
        .fwdB         (fwdB),
        .aluResultFwd (aluResultM), // lw result is not ready here yet
        .resultW      (resultW),
        .takenE       (takenE),
        .targetE      (targetE),
        .aluResultM   (aluResultM),
        .writeDataM   (writeDataM),
        .pcPlus4M     (pcPlus4M),
        .rdM          (rdM),
        .regWriteM    (regWriteM),
        .memWriteM    (memWriteM),
        .resultSrcM   (resultSrcM)
    );

    // memory stage drives the data port directly
    assign dmemAddr      = aluResultM;
    assign dmemWriteData = writeDataM;
    assign dmemWrite     = memWriteM;

    memWriteback memWb (
        .clk          (clk),
        .rst          (rst),
        .aluResultM   (aluResultM),
        .dmemReadData (dmemReadData),
        .pcPlus4M     (pcPlus4M),
        .rdM          (rdM),
        .regWriteM    (regWriteM),
        .resultSrcM   (resultSrcM),
        .resultW      (resultW),
        .rdW          (rdW),
        .regWriteW    (regWriteW)
    );

endmodule

// ==== tb/tbProgram.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// program layout, word indices and byte addresses
localparam int FIRST_SW_IDX  = 5;
localparam int TAKEN_BEQ_IDX = 21;  // beq x1, x1 jumps 4 words ahead
localparam int JAL_IDX       = 29;  // jal x14 jumps 4 words ahead
localparam int LOOP_IDX      = 34;  // jal x0 to itself
localparam int SKIP_ADDR_A   = 100; // sw behind the taken beq
localparam int SKIP_ADDR_B   = 124; // sw behind the jal

function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [2:0] f3,
                                          input int rd, input int rs1, input int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_RTYPE};
endfunction

// lw and addi share the I layout
function automatic logic [31:0] immWord(input logic [6:0] op, input logic [2:0] f3,
                                        input int rd, input int rs1, input int imm);
    return {12'(imm), 5'(rs1), f3, 5'(rd), op};
endfunction

function automatic logic [31:0] storeWord(input int rs2, input int rs1, input int imm);
    logic [11:0] i;
    i = 12'(imm);
    return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], OP_STORE};
endfunction

function automatic logic [31:0] beqWord(input int rs1, input int rs2, input int imm);
    logic [12:0] i;
    i = 13'(imm); // byte offset, bit 0 dropped
    return {i[12], i[10:5], 5'(rs2), 5'(rs1), 3'b000, i[4:1], i[11], OP_BRANCH};
endfunction

function automatic logic [31:0] jalWord(input int rd, input int imm);
    logic [20:0] i;
    i = 21'(imm);
    return {i[20], i[10:1], i[11], i[19:12], 5'(rd), OP_JAL};
endfunction

////////////////////
// test program, x1..x4 and x11 come from dmem words 0..4
function automatic logic [31:0] progWord(input int idx);
    case (idx)
        0:  return immWord(OP_LOAD, 3'b010, 1, 0, 0);
        1:  return immWord(OP_LOAD, 3'b010, 2, 0, 4);
        2:  return immWord(OP_LOAD, 3'b010, 3, 0, 8);
        3:  return immWord(OP_LOAD, 3'b010, 4, 0, 12);
        4:  return rTypeWord(7'h00, 3'b000, 5, 1, 2);   // add
        5:  return storeWord(5, 0, 64);                 // distance 1
        6:  return rTypeWord(7'h20, 3'b000, 6, 3, 4);   // sub
        7:  return storeWord(6, 0, 68);
        8:  return rTypeWord(7'h00, 3'b111, 7, 1, 3);   // and
        9:  return rTypeWord(7'h00, 3'b110, 8, 2, 4);   // or
        10: return storeWord(7, 0, 72);                 // distance 2
        11: return storeWord(8, 0, 76);
        12: return rTypeWord(7'h00, 3'b010, 9, 1, 2);   // slt
        13: return immWord(OP_IMM, 3'b000, 10, 9, 100);
        14: return storeWord(10, 0, 80);
        15: return immWord(OP_LOAD, 3'b010, 11, 0, 16);
        16: return immWord(OP_IMM, 3'b000, 12, 0, 7);
        17: return rTypeWord(7'h00, 3'b000, 13, 11, 12); // load used two later
        18: return storeWord(13, 0, 84);
        19: return immWord(OP_IMM, 3'b000, 0, 1, 5);    // write to x0
        20: return storeWord(0, 0, 88);
        21: return beqWord(1, 1, 16);
        22: return storeWord(1, 0, 92);                 // shadow, runs
        23: return storeWord(2, 0, 96);                 // shadow, runs
        24: return storeWord(3, 0, SKIP_ADDR_A);
        25: return beqWord(12, 0, 12);                  // 7 != 0, falls through
        26: return storeWord(4, 0, 104);
        27: return storeWord(6, 0, 108);
        28: return storeWord(7, 0, 112);
        29: return jalWord(14, 16);
        30: return storeWord(8, 0, 116);
        31: return storeWord(9, 0, 120);
        32: return storeWord(1, 0, SKIP_ADDR_B);
        33: return storeWord(14, 0, 128);               // link value
        34: return jalWord(0, 0);
        default: return 32'h0; // opcode 0 runs as a bubble
    endcase
endfunction

// redirect target of a word in execute, -1 when it falls through
function automatic int takenTarget(input int idx);
    case (idx)
        TAKEN_BEQ_IDX: return TAKEN_BEQ_IDX + 4;
        JAL_IDX:       return JAL_IDX + 4;
        LOOP_IDX:      return LOOP_IDX;
        default:       return -1;
    endcase
endfunction

`endif

// ==== tb/riscvCoreTb.sv ====
`timescale 1ns/1ns

module riscvCoreTb import riscvPkg::*; ();

    `include "tbProgram.svh"

    localparam int IMEM_ADDR_W    = 6;
    localparam int NUM_STORES     = 15;
    localparam int TRACE_LEN      = 40;  // fetch cycles modelled
    localparam int TIMEOUT_CYCLES = 200;
    localparam int DRAIN_CYCLES   = 20;

    logic                   clk;
    logic                   rst;
    logic [IMEM_ADDR_W-1:0] imemAddr;
    logic [XLEN-1:0]        imemData;
    logic [XLEN-1:0]        dmemReadData;
    logic                   dmemWrite;
    logic [XLEN-1:0]        dmemAddr;
    logic [XLEN-1:0]        dmemWriteData;

    logic [XLEN-1:0] imem [2**IMEM_ADDR_W];
    logic [XLEN-1:0] dmem [64];
    logic [XLEN-1:0] expAddr [NUM_STORES];
    logic [XLEN-1:0] expData [NUM_STORES];
    int              fetchTrace [TRACE_LEN]; // expected imemAddr per cycle
    int              expCount;
    int              storeIdx;
    int              cycleCnt;  // cycles since reset release
    int              errors;
    int              timeouts;

    riscvCore #(.IMEM_ADDR_W(IMEM_ADDR_W)) uut (
        .clk           (clk),
        .rst           (rst),
        .imemData      (imemData),
        .imemAddr      (imemAddr),
        .dmemReadData  (dmemReadData),
        .dmemWrite     (dmemWrite),
        .dmemAddr      (dmemAddr),
        .dmemWriteData (dmemWriteData)
    );

    always #2 clk = ~clk;

    ////////////////////
    // memory models
    assign imemData     = imem[imemAddr];
    assign dmemReadData = dmem[dmemAddr[7:2]]; // word addressed

    always @(posedge clk) begin
        if (dmemWrite)
            dmem[dmemAddr[7:2]] <= dmemWriteData;
    end

    always @(posedge clk, posedge rst) begin
        if (rst) begin
            storeIdx <= 0;
            cycleCnt <= 0;
        end else begin
            cycleCnt <= cycleCnt + 1;
            if (dmemWrite)
                storeIdx <= storeIdx + 1;
        end
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic addStore(input int addr, input logic [31:0] data);
        expAddr[expCount] = 32'(addr);
        expData[expCount] = data;
        expCount++;
    endtask

    task automatic buildExpected();
        logic [31:0] seed;
        logic [31:0] lt;
        int          pc;
        seed = 32'd11520;
        for (int i = 0; i < 64; i++) begin
            imem[i] = progWord(i);
            if (i < 8) begin
                seed    = lcgNext(seed);
                dmem[i] = seed;
            end else begin
                dmem[i] = 32'h5A5A_0000 ^ 32'(i * 4); // marks the byte address
            end
        end
        lt       = (dmem[0] < dmem[1]) ? 32'd1 : 32'd0; // unsigned slt
        expCount = 0;
        addStore(64, dmem[0] + dmem[1]);
        addStore(68, dmem[2] - dmem[3]);
        addStore(72, dmem[0] & dmem[2]);
        addStore(76, dmem[1] | dmem[3]);
        addStore(80, lt + 32'd100);
        addStore(84, dmem[4] + 32'd7);
        addStore(88, 32'd0);                  // x0 stays zero
        addStore(92, dmem[0]);
        addStore(96, dmem[1]);
        addStore(104, dmem[3]);
        addStore(108, dmem[2] - dmem[3]);
        addStore(112, dmem[0] & dmem[2]);
        addStore(116, dmem[1] | dmem[3]);
        addStore(120, lt);
        addStore(128, 32'(JAL_IDX * 4 + 4));  // link address
        pc = 0;
        for (int c = 0; c < TRACE_LEN; c++) begin
            fetchTrace[c] = pc;
            // word fetched two cycles back sits in execute now
            if (c >= 2 && takenTarget(fetchTrace[c-2]) >= 0)
                pc = takenTarget(fetchTrace[c-2]);
            else
                pc = pc + 1;
        end
    endtask

    ////////////////////
    // checks, sampled mid cycle
    assert property (@(negedge clk) disable iff (rst)
        cycleCnt >= TRACE_LEN || imemAddr == IMEM_ADDR_W'(fetchTrace[cycleCnt]))
    else begin
        errors = errors + 1;
        $display("[ERROR] imemAddr cycle %0d: got %h expected %h",
                 cycleCnt, imemAddr, IMEM_ADDR_W'(fetchTrace[cycleCnt]));
    end

    assert property (@(negedge clk) disable iff (rst)
        cycleCnt >= FIRST_SW_IDX + 3 || !dmemWrite)
    else begin
        errors = errors + 1;
        $display("dmemWrite went high in cycle %0d, before the first store", cycleCnt);
    end

    assert property (@(negedge clk) disable iff (rst)
        !dmemWrite || storeIdx >= NUM_STORES || dmemAddr == expAddr[storeIdx])
    else begin
        errors = errors + 1;
        $display("[ERROR] dmemAddr store %0d: got %h expected %h",
                 storeIdx, dmemAddr, expAddr[storeIdx]);
    end

    assert property (@(negedge clk) disable iff (rst)
        !dmemWrite || storeIdx >= NUM_STORES || dmemWriteData == expData[storeIdx])
    else begin
        errors = errors + 1;
        $display("[ERROR] dmemWriteData store %0d: got %h expected %h",
                 storeIdx, dmemWriteData, expData[storeIdx]);
    end

    assert property (@(negedge clk) disable iff (rst)
        !dmemWrite || (dmemAddr != SKIP_ADDR_A && dmemAddr != SKIP_ADDR_B))
    else begin
        errors = errors + 1;
        $display("a skipped instruction stored to address %h", dmemAddr);
    end

    assert property (@(negedge clk) disable iff (rst)
        !dmemWrite || storeIdx < NUM_STORES)
    else begin
        errors = errors + 1;
        $display("an extra store appeared after the last expected one, address %h", dmemAddr);
    end

    initial begin
        int waitCnt;
        clk      = 1'b0;
        rst      = 1'b1;
        errors   = 0;
        timeouts = 0;
        buildExpected();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        waitCnt = 0;
        while (storeIdx < NUM_STORES && waitCnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            waitCnt++;
        end
        if (storeIdx < NUM_STORES) begin
            $display("timeout: only %0d of %0d stores seen", storeIdx, NUM_STORES);
            timeouts++;
        end
        // core spins in its jal loop, late stores would show here
        waitCnt = 0;
        while (waitCnt < DRAIN_CYCLES) begin
            @(posedge clk);
            waitCnt++;
        end
        $display("errors %0d, timeouts %0d, stores seen %0d", errors, timeouts, storeIdx);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== riscvPipe.f ====
common/riscvPkg.sv
design/controlDecoder.sv
design/forwardingUnit.sv
fetch/fetchStage.sv
decode/regFile.sv
decode/decodeStage.sv
execute/executeStage.sv
design/memWriteback.sv
design/riscvCore.sv
tb/riscvCoreTb.sv
+incdir+tb

// ==== run.sh ====
#!/bin/sh
# build with Verilator, then look for the pass message in the simulation output
verilator --binary --timing --assert -f riscvPipe.f --top-module riscvCoreTb -o simv || exit 1
out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -q "All tests passed!" && exit 0 || exit 1
